// File: fpPostConsts.svh
// width constants for the fp post-processing path
// single precision format, integer conversion widths, rounding mode

`ifndef FP_POST_CONSTS_SVH
`define FP_POST_CONSTS_SVH

////////////////////////////////////////
// floating-point format
////////////////////////////////////////

`define FP_NE   8   // exponent bits
`define FP_NF   23  // fraction bits, hidden one not counted
`define FP_FLEN 32  // full result width

////////////////////////////////////////
// conversion integer
////////////////////////////////////////

`define INT_XLEN   64  // widest integer result
`define INT_NARROW 32  // 32-bit conversions, sign-extended to XLEN

`define FRM_W 3  // rounding mode field, RISC-V encoding

`endif

// File: fpPostPkg.sv
// types for the fp post-processing path
// operation and case enums, input bundle, stage payloads

`default_nettype none

`include "fpPostConsts.svh"

package fpPostPkg;

  // one-hot op bits of the rounding stage collapsed into one code
  typedef enum logic [1:0] {opFma, opDiv, opCvt, opOther} opT;

  // fp result cases, listed in priority order
  typedef enum logic [2:0] {
    selXNaN, selYNaN, selZNaN, selInvalid, selOverflow, selUnderflow, selNormal
  } fpSelT;

  // integer result cases
  typedef enum logic [2:0] {intOfNeg, intOfPos, intUfOnes, intUfRound, intNormal} intSelT;

  ////////////////////////////////////////
  // bundle from normalize / round
  ////////////////////////////////////////
  typedef struct packed {
    logic                  xs;                  // x sign
    logic [`FP_NF:0]       xm, ym, zm;          // significands, carry nan payloads
    logic                  xNaN, yNaN, zNaN;
    logic [`FRM_W-1:0]     frm;                 // rounding mode
    logic                  infIn, nanIn;        // any input inf / nan
    logic                  xInf, yInf, xZero;
    logic                  plus1;               // rounding adds one
    logic                  rs;                  // result sign
    logic                  invalid, overflow;
    logic [`FP_NE-1:0]     re;                  // rounded exponent
    logic [`FP_NE+1:0]     fullRe;              // exponent with guard bits, msb = negative
    logic [`FP_NF-1:0]     rf;                  // rounded fraction
    opT                    op;
    logic                  divByZero;
    logic                  intZero;             // integer input is zero
    logic                  intToFp, int64, isSigned;
    logic [`FP_NE:0]       cvtCe;               // cvt exponent, msb = underflow
    logic                  intInvalid, cvtResUf;
    logic [`INT_XLEN+1:0]  cvtNegRes;           // integer result, negated if needed
  } postInT;

  // decisions made in stage one plus only the fields stage two needs
  typedef struct packed {
    fpSelT                 fpSel;
    intSelT                intSel;
    logic                  ofResMax;            // max normal instead of inf
    logic                  ufLsb;               // smallest subnormal instead of zero
    logic                  rs;
    logic [`FP_NE-1:0]     re;
    logic [`FP_NF-1:0]     rf;
    logic [`FP_NF-2:0]     xPay, yPay, zPay;    // nan payloads below the quiet bit
    logic                  int64, isSigned, plus1;
    logic [`INT_XLEN-1:0]  cvtNegRes;
  } classT;

  typedef struct packed {
    logic [`FP_FLEN-1:0]   fpRes;
    logic [`INT_XLEN-1:0]  intRes;
  } resultT;

endpackage

`default_nettype wire

// File: stageReg.sv
// pipeline register, valid bit plus a payload of any packed type

`timescale 1ns/1ps
`default_nettype none

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  input  payloadT inData,
  output logic    outValid,
  output payloadT outData
);

  // control bit, cleared by reset
  always_ff @(posedge clk) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= inValid;
  end

  // payload only loads on a strobe, held otherwise
  always_ff @(posedge clk) begin
    if (inValid) outData <= inData;
  end

  // no stale item may leave right after reset
  aValidClearAfterReset : assert property (
    @(posedge clk) !rstN |=> !outValid
  ) else $error("stageReg: outValid high in cycle after reset");

endmodule

`default_nettype wire

// File: resultClassify.sv
// stage one of fp post-processing
// picks the fp special case, the integer case and the result modifiers

`timescale 1ns/1ps
`default_nettype none

`include "fpPostConsts.svh"

module resultClassify (
  input  fpPostPkg::postInT postIn,
  output fpPostPkg::classT  cls
);

  logic isFma, isDiv, isCvt;   // decoded op
  logic xNaNSel;               // x nan applies to this op
  logic yNaNSel;
  logic zNaNSel;
  logic selOfRes;              // overflow pattern wins
  logic killRes;               // underflow pattern wins
  logic negIn;                 // negative and not a nan, for saturation

  assign isFma = (postIn.op == fpPostPkg::opFma);
  assign isDiv = (postIn.op == fpPostPkg::opDiv);
  assign isCvt = (postIn.op == fpPostPkg::opCvt);

  ////////////////////////////////////////
  // fp case flags
  ////////////////////////////////////////

  assign xNaNSel = postIn.xNaN & ~(postIn.intToFp & isCvt);  // int input has no x nan
  assign yNaNSel = postIn.yNaN & ~isCvt;                     // cvt has no y operand
  assign zNaNSel = postIn.zNaN & isFma;                      // z only exists in fma

  // inf input gives inf, except x/inf which goes to zero
  assign selOfRes = postIn.overflow | postIn.divByZero
                  | (postIn.infIn & ~(postIn.yInf & isDiv));

  // cvt: ignore a zero on the side that is not the source
  always_comb begin
    if (isCvt)
      killRes = postIn.cvtResUf | (postIn.xZero & ~postIn.intToFp)
              | (postIn.intZero & postIn.intToFp);
    else
      killRes = postIn.fullRe[`FP_NE+1]                    // exponent went negative
              | (((postIn.yInf & ~postIn.xInf) | postIn.xZero) & isDiv);
  end

  // rtz, rdn with +, rup with - stop at max normal
  assign cls.ofResMax = (~postIn.infIn | (postIn.intToFp & isCvt)) & ~postIn.divByZero
                      & ((postIn.frm[1:0] == 2'b01)
                      |  (postIn.frm[1:0] == 2'b10 & ~postIn.rs)
                      |  (postIn.frm[1:0] == 2'b11 &  postIn.rs));

  // x/inf is an exact zero, never round it up
  assign cls.ufLsb = postIn.plus1 & postIn.frm[1] & ~(isDiv & postIn.yInf);

  always_comb begin
    if (xNaNSel)              cls.fpSel = fpPostPkg::selXNaN;
    else if (yNaNSel)         cls.fpSel = fpPostPkg::selYNaN;
    else if (zNaNSel)         cls.fpSel = fpPostPkg::selZNaN;
    else if (postIn.invalid)  cls.fpSel = fpPostPkg::selInvalid;
    else if (selOfRes)        cls.fpSel = fpPostPkg::selOverflow;
    else if (killRes)         cls.fpSel = fpPostPkg::selUnderflow;
    else                      cls.fpSel = fpPostPkg::selNormal;
  end

  ////////////////////////////////////////
  // integer case
  ////////////////////////////////////////

  assign negIn = postIn.xs & ~postIn.nanIn;  // nan saturates positive

  always_comb begin
    if (postIn.intInvalid)
      cls.intSel = negIn ? fpPostPkg::intOfNeg : fpPostPkg::intOfPos;
    else if (postIn.cvtCe[`FP_NE])  // magnitude below one
      cls.intSel = (postIn.xs & postIn.isSigned & postIn.plus1) ? fpPostPkg::intUfOnes
                                                                : fpPostPkg::intUfRound;
    else
      cls.intSel = fpPostPkg::intNormal;
  end

  // fields carried into stage two
  assign cls.rs        = postIn.rs;
  assign cls.re        = postIn.re;
  assign cls.rf        = postIn.rf;
  assign cls.xPay      = postIn.xm[`FP_NF-2:0];
  assign cls.yPay      = postIn.ym[`FP_NF-2:0];
  assign cls.zPay      = postIn.zm[`FP_NF-2:0];
  assign cls.int64     = postIn.int64;
  assign cls.isSigned  = postIn.isSigned;
  assign cls.plus1     = postIn.plus1;
  assign cls.cvtNegRes = postIn.cvtNegRes[`INT_XLEN-1:0];  // top two bits only hold overflow

  // the stage-two decoders rely on a legal case code
  always_comb begin
    if (!$isunknown(postIn))
      assert (cls.fpSel inside {fpPostPkg::selXNaN, fpPostPkg::selYNaN, fpPostPkg::selZNaN,
                                fpPostPkg::selInvalid, fpPostPkg::selOverflow,
                                fpPostPkg::selUnderflow, fpPostPkg::selNormal})
        else $error("resultClassify: illegal fpSel %0d", cls.fpSel);
  end

endmodule

`default_nettype wire

// File: fpResultBuild.sv
// stage two, fp side
// builds the result pattern for the case picked in stage one

`timescale 1ns/1ps
`default_nettype none

`include "fpPostConsts.svh"

module fpResultBuild (
  input  fpPostPkg::classT     cls,
  output logic [`FP_FLEN-1:0]  fpRes
);

  logic [`FP_FLEN-1:0] xNaNRes;    // quieted x, payload kept
  logic [`FP_FLEN-1:0] yNaNRes;
  logic [`FP_FLEN-1:0] zNaNRes;
  logic [`FP_FLEN-1:0] invalidRes; // canonical nan
  logic [`FP_FLEN-1:0] ofRes;
  logic [`FP_FLEN-1:0] ufRes;
  logic [`FP_FLEN-1:0] normRes;

  ////////////////////////////////////////
  // candidate patterns
  ////////////////////////////////////////

  // positive sign, all-ones exponent, quiet bit set
  assign xNaNRes    = {1'b0, {`FP_NE{1'b1}}, 1'b1, cls.xPay};
  assign yNaNRes    = {1'b0, {`FP_NE{1'b1}}, 1'b1, cls.yPay};
  assign zNaNRes    = {1'b0, {`FP_NE{1'b1}}, 1'b1, cls.zPay};
  assign invalidRes = {1'b0, {`FP_NE{1'b1}}, 1'b1, {`FP_NF-1{1'b0}}};  // 7fc00000

  // largest normal has exponent fe and all-ones fraction
  always_comb begin
    if (cls.ofResMax)
      ofRes = {cls.rs, {`FP_NE-1{1'b1}}, 1'b0, {`FP_NF{1'b1}}};
    else
      ofRes = {cls.rs, {`FP_NE{1'b1}}, {`FP_NF{1'b0}}};  // signed inf
  end

  assign ufRes   = {cls.rs, {`FP_FLEN-2{1'b0}}, cls.ufLsb};  // zero or min subnormal
  assign normRes = {cls.rs, cls.re, cls.rf};                 // pass-through

  ////////////////////////////////////////
  // select
  ////////////////////////////////////////

  always_comb begin
    case (cls.fpSel)
      fpPostPkg::selXNaN:      fpRes = xNaNRes;
      fpPostPkg::selYNaN:      fpRes = yNaNRes;
      fpPostPkg::selZNaN:      fpRes = zNaNRes;
      fpPostPkg::selInvalid:   fpRes = invalidRes;
      fpPostPkg::selOverflow:  fpRes = ofRes;
      fpPostPkg::selUnderflow: fpRes = ufRes;
      default:                 fpRes = normRes;
    endcase
  end

endmodule

`default_nettype wire

// File: intResultBuild.sv
// stage two, integer side
// saturation table, sub-one rounding and 32-bit sign extension

`timescale 1ns/1ps
`default_nettype none

`include "fpPostConsts.svh"

module intResultBuild (
  input  fpPostPkg::classT      cls,
  output logic [`INT_XLEN-1:0]  intRes
);

  localparam int Ext = `INT_XLEN - `INT_NARROW;  // bits above a 32-bit result

  logic [`INT_XLEN-1:0] satNeg;  // out of range below, or -inf
  logic [`INT_XLEN-1:0] satPos;  // out of range above, +inf or nan

  // signed: min / max of the chosen width; unsigned: 0 / all ones
  always_comb begin
    if (cls.isSigned) begin
      satNeg = cls.int64 ? {1'b1, {`INT_XLEN-1{1'b0}}}
                         : {{Ext{1'b1}}, 1'b1, {`INT_NARROW-1{1'b0}}};
      satPos = cls.int64 ? {1'b0, {`INT_XLEN-1{1'b1}}}
                         : {{Ext+1{1'b0}}, {`INT_NARROW-1{1'b1}}};
    end else begin
      satNeg = '0;
      satPos = '1;  // 32-bit unsigned max also sign-extends to all ones
    end
  end

  always_comb begin
    case (cls.intSel)
      fpPostPkg::intOfNeg:   intRes = satNeg;
      fpPostPkg::intOfPos:   intRes = satPos;
      fpPostPkg::intUfOnes:  intRes = '1;                                 // rounds to -1
      fpPostPkg::intUfRound: intRes = {{`INT_XLEN-1{1'b0}}, cls.plus1};  // 0 or 1
      default:
        if (cls.int64) intRes = cls.cvtNegRes;
        else           intRes = {{Ext{cls.cvtNegRes[`INT_NARROW-1]}},
                                 cls.cvtNegRes[`INT_NARROW-1:0]};
    endcase
  end

  // narrow results sit sign-extended in the xlen register
  always_comb begin
    if (cls.intSel == fpPostPkg::intNormal && !cls.int64 && !$isunknown(cls.cvtNegRes))
      assert (intRes[`INT_XLEN-1:`INT_NARROW] == {Ext{intRes[`INT_NARROW-1]}})
        else $error("intResultBuild: 32-bit result not sign-extended %h", intRes);
  end

endmodule

`default_nettype wire

// File: fpPostProc.sv
// top of the fp post-processing path
// classify, register, build fp and int results, register

`timescale 1ns/1ps
`default_nettype none

`include "fpPostConsts.svh"

module fpPostProc (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,   // one strobe per item
  input  fpPostPkg::postInT  postIn,
  output logic               outValid,  // two cycles after inValid
  output fpPostPkg::resultT  result
);

  fpPostPkg::classT      clsD;      // stage one, combinational
  fpPostPkg::classT      clsQ;      // stage one, registered
  logic                  clsValid;
  logic [`FP_FLEN-1:0]   fpResD;
  logic [`INT_XLEN-1:0]  intResD;

  ////////////////////////////////////////
  // stage one
  ////////////////////////////////////////

  resultClassify uClassify (
    .postIn (postIn),
    .cls    (clsD)
  );

  stageReg #(.payloadT(fpPostPkg::classT)) uClsReg (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inData   (clsD),
    .outValid (clsValid),
    .outData  (clsQ)
  );

  ////////////////////////////////////////
  // stage two
  ////////////////////////////////////////

  fpResultBuild uFpBuild (
    .cls   (clsQ),
    .fpRes (fpResD)
  );

  intResultBuild uIntBuild (
    .cls    (clsQ),
    .intRes (intResD)
  );

  stageReg #(.payloadT(fpPostPkg::resultT)) uResReg (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (clsValid),
    .inData   ({fpResD, intResD}),  // same field order as resultT
    .outValid (outValid),
    .outData  (result)
  );

endmodule

`default_nettype wire

// File: tb_fpPostProc.sv
// testbench for fpPostProc
// directed and random bundles, reference rules, two-deep expected queue
// concurrent checks on outValid and both results

`timescale 1ns/1ps
`default_nettype none

module tb_fpPostProc;

  logic clk, rstN, inValid, outValid;
  fpPostPkg::postInT postIn;
  fpPostPkg::resultT result;

  integer seed = 32'hd1d0_bc97;
  int curTest = 0;                        // name index of the item on the inputs
  int cycleCount = 0;
  int cycleLimit = 0;                     // 0 until the stimulus is built
  int errValid = 0, errFp = 0, errInt = 0, errReset = 0;
  fpPostPkg::postInT stimQ[$];
  int testQ[$];                           // -1 marks an idle cycle
  string testNames[7] = '{"random", "nan_priority", "invalid", "overflow", "kill",
                          "normal", "int_result"};

  logic [1:0] expV = '0;                  // expected valid, [1] is the head
  fpPostPkg::resultT expR[2];
  int expT[2] = '{0, 0};

  fpPostProc UUT (
    .clk(clk), .rstN(rstN), .inValid(inValid), .postIn(postIn),
    .outValid(outValid), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;               // 4 ns period
  end

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  function automatic fpPostPkg::resultT expectFor(input fpPostPkg::postInT p);
    fpPostPkg::resultT r;
    logic fma, div, cvt, maxNorm, addLsb, kill, neg;
    fma = (p.op == fpPostPkg::opFma);
    div = (p.op == fpPostPkg::opDiv);
    cvt = (p.op == fpPostPkg::opCvt);
    // rtz, rdn positive, rup negative stop at the largest normal
    maxNorm = ((p.frm == 3'd1) || (p.frm == 3'd2 && !p.rs) || (p.frm == 3'd3 && p.rs))
              && (!p.infIn || (cvt && p.intToFp)) && !p.divByZero;
    addLsb = p.plus1 && p.frm[1] && !(div && p.yInf);
    if (cvt) kill = p.cvtResUf || (p.xZero && !p.intToFp) || (p.intZero && p.intToFp);
    else     kill = p.fullRe[9] || (div && ((p.yInf && !p.xInf) || p.xZero));
    if (p.xNaN && !(cvt && p.intToFp)) r.fpRes = {1'b0, 8'hff, 1'b1, p.xm[21:0]};
    else if (p.yNaN && !cvt)           r.fpRes = {1'b0, 8'hff, 1'b1, p.ym[21:0]};
    else if (p.zNaN && fma)            r.fpRes = {1'b0, 8'hff, 1'b1, p.zm[21:0]};
    else if (p.invalid)                r.fpRes = 32'h7fc0_0000;
    else if (p.overflow || p.divByZero || (p.infIn && !(div && p.yInf)))
      r.fpRes = maxNorm ? {p.rs, 8'hfe, 23'h7f_ffff} : {p.rs, 8'hff, 23'h0};
    else if (kill)                     r.fpRes = {p.rs, 30'h0, addLsb};
    else                               r.fpRes = {p.rs, p.re, p.rf};
    neg = p.xs && !p.nanIn;              // nan saturates like +inf
    if (p.intInvalid) begin
      if (!p.isSigned)    r.intRes = neg ? 64'h0 : {64{1'b1}};
      else if (p.int64)   r.intRes = neg ? 64'h8000_0000_0000_0000 : 64'h7fff_ffff_ffff_ffff;
      else                r.intRes = neg ? 64'hffff_ffff_8000_0000 : 64'h0000_0000_7fff_ffff;
    end else if (p.cvtCe[8]) begin
      r.intRes = (p.xs && p.isSigned && p.plus1) ? {64{1'b1}} : {63'h0, p.plus1};
    end else begin
      r.intRes = p.int64 ? p.cvtNegRes[63:0]
                         : {{32{p.cvtNegRes[31]}}, p.cvtNegRes[31:0]};
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  function automatic fpPostPkg::postInT randomBundle();
    logic [255:0] raw;
    fpPostPkg::postInT p;
    for (int i = 0; i < 8; i++) raw[i*32 +: 32] = $random(seed);
    p = raw[$bits(fpPostPkg::postInT)-1:0];
    p.frm = 3'($unsigned($random(seed)) % 5);  // legal modes only
    return p;
  endfunction

  // random fields, every special-case flag cleared
  function automatic fpPostPkg::postInT quietBase();
    fpPostPkg::postInT p;
    p = randomBundle();
    {p.xNaN, p.yNaN, p.zNaN, p.nanIn, p.infIn, p.xInf, p.yInf, p.xZero} = '0;
    {p.invalid, p.overflow, p.divByZero, p.intZero, p.intInvalid, p.cvtResUf} = '0;
    p.fullRe[9] = 1'b0;
    p.cvtCe[8]  = 1'b0;
    p.op        = fpPostPkg::opOther;
    return p;
  endfunction

  task automatic push(input fpPostPkg::postInT p, input int id);
    stimQ.push_back(p);
    testQ.push_back(id);
  endtask

  task automatic buildStimulus();
    fpPostPkg::postInT p;
    for (int o = 0; o < 4; o++)          // every op, int or fp source, nan subsets
      for (int t = 0; t < 2; t++)
        for (int m = 1; m < 8; m++) begin
          p = quietBase();
          p.op = fpPostPkg::opT'(o[1:0]);
          p.intToFp = t[0];
          {p.zNaN, p.yNaN, p.xNaN} = m[2:0];
          p.nanIn = 1'b1;
          p.invalid = 1'b1;              // lower priority than any nan
          push(p, 1);
        end
    push('0, -1);
    for (int o = 0; o < 4; o++) begin
      p = quietBase();
      p.op = fpPostPkg::opT'(o[1:0]);
      p.invalid = 1'b1;
      p.overflow = o[0];
      push(p, 2);
    end
    for (int f = 0; f < 5; f++)
      for (int s = 0; s < 2; s++) begin
        p = quietBase();
        p.frm = f[2:0];
        p.rs = s[0];
        p.overflow = 1'b1;
        push(p, 3);
        p.overflow = 1'b0;
        p.op = fpPostPkg::opDiv;
        p.divByZero = 1'b1;              // always inf
        push(p, 3);
        p.divByZero = 1'b0;
        p.op = fpPostPkg::opFma;
        p.infIn = 1'b1;                  // inf operand, always inf
        push(p, 3);
        p.op = fpPostPkg::opCvt;
        p.intToFp = 1'b1;                // int source keeps the rounding rule
        push(p, 3);
      end
    push('0, -1);
    for (int f = 0; f < 5; f++)
      for (int u = 0; u < 2; u++)
        for (int k = 0; k < 6; k++) begin
          p = quietBase();
          p.frm = f[2:0];
          p.plus1 = u[0];
          case (k)
            0: begin
              p.op = fpPostPkg::opCvt;
              p.cvtResUf = 1'b1;
            end
            1: begin
              p.op = fpPostPkg::opCvt;
              p.xZero = 1'b1;
              p.intToFp = 1'b0;
            end
            2: begin
              p.op = fpPostPkg::opCvt;
              p.intZero = 1'b1;
              p.intToFp = 1'b1;
            end
            3: p.fullRe[9] = 1'b1;
            4: begin
              p.op = fpPostPkg::opDiv;
              p.yInf = 1'b1;
              p.infIn = 1'b1;
            end
            default: begin
              p.op = fpPostPkg::opDiv;
              p.xZero = 1'b1;
            end
          endcase
          push(p, 4);
        end
    push('0, -1);
    for (int i = 0; i < 8; i++) push(quietBase(), 5);
    for (int c = 0; c < 16; c++) begin   // saturation table incl. nan
      p = quietBase();
      p.intInvalid = 1'b1;
      {p.isSigned, p.int64, p.xs, p.nanIn} = c[3:0];
      push(p, 6);
    end
    for (int c = 0; c < 8; c++) begin    // magnitude below one
      p = quietBase();
      p.cvtCe[8] = 1'b1;
      {p.xs, p.isSigned, p.plus1} = c[2:0];
      push(p, 6);
    end
    for (int c = 0; c < 8; c++) begin
      p = quietBase();
      p.int64 = c[0];
      p.cvtNegRes[31] = c[1];            // both halves of the sign extension
      push(p, 6);
    end
    push('0, -1);
    for (int i = 0; i < 40; i++) push(randomBundle(), 0);
  endtask

  task automatic driveItem(input fpPostPkg::postInT p, input int id);
    @(posedge clk);
    #1;
    inValid = 1'b1;
    postIn  = p;
    curTest = id;
  endtask

  task automatic driveIdle();
    @(posedge clk);
    #1;
    inValid = 1'b0;
  endtask

  ////////////////////////////////////////
  // expected queue and checks
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstN) expV <= '0;
    else       expV <= {expV[0], inValid};
    expR[0] <= expectFor(postIn);
    expR[1] <= expR[0];
    expT[0] <= curTest;
    expT[1] <= expT[0];
  end

  aResetClear : assert property (@(posedge clk) !rstN |=> !outValid)
    else begin
      errReset++;
      $display("outValid was high in the cycle after reset");
    end

  aLatency : assert property (@(posedge clk) disable iff (!rstN) outValid == expV[1])
    else begin
      errValid++;
      $display("ERROR %s: outValid expected %0b actual %0b", testNames[$sampled(expT[1])],
               $sampled(expV[1]), $sampled(outValid));
    end

  aFpRes : assert property (@(posedge clk) disable iff (!rstN)
                            outValid |-> result.fpRes == expR[1].fpRes)
    else begin
      errFp++;
      $display("ERROR %s: fpRes expected %h actual %h", testNames[$sampled(expT[1])],
               $sampled(expR[1].fpRes), $sampled(result.fpRes));
    end

  aIntRes : assert property (@(posedge clk) disable iff (!rstN)
                             outValid |-> result.intRes == expR[1].intRes)
    else begin
      errInt++;
      $display("ERROR %s: intRes expected %h actual %h", testNames[$sampled(expT[1])],
               $sampled(expR[1].intRes), $sampled(result.intRes));
    end

  // watchdog
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout, the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    rstN    = 1'b0;
    inValid = 1'b0;
    postIn  = '0;
    buildStimulus();
    cycleLimit = 2 * stimQ.size() + 20;
    repeat (4) @(posedge clk);
    #1 rstN = 1'b1;
    foreach (stimQ[i]) begin
      if (testQ[i] < 0) driveIdle();
      else              driveItem(stimQ[i], testQ[i]);
    end
    driveIdle();
    repeat (4) @(posedge clk);           // drain both stages
    // reset again with both stages full and the strobe still high
    driveItem(quietBase(), 5);
    driveItem(quietBase(), 5);
    @(posedge clk);
    #1 rstN = 1'b0;
    @(posedge clk);
    #1;
    rstN    = 1'b1;
    inValid = 1'b0;
    repeat (4) @(posedge clk);
    $display("errors: reset %0d, latency %0d, fpRes %0d, intRes %0d",
             errReset, errValid, errFp, errInt);
    if (errReset + errValid + errFp + errInt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: fpPostProc.f
+incdir+.
fpPostPkg.sv
stageReg.sv
resultClassify.sv
fpResultBuild.sv
intResultBuild.sv
fpPostProc.sv
tb_fpPostProc.sv

// File: Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_fpPostProc
DUT       := fpPostProc
FLIST     := fpPostProc.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS      := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

# the simulator status is not trusted, the log decides
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(DUT) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
